// File: source/ctrl_regs.sv
/*
 * Control register target
 *   writable exit code and hardware-counter enable
 *   read-only DRAM base and end, error on write or unknown offset
 *   one-cycle response held until taken
 */

module ctrl_regs import soc_pkg::*; (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  soc_req_t req_i,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  output soc_rsp_t rsp_o,
  output logic     rsp_valid_o,
  input  logic     rsp_ready_i,
  output data_t    exit_o,
  output data_t    hw_cnt_en_o
);

  addr_t offs;
  logic  accept;
  data_t rd_data;
  logic  rd_error;

  assign offs        = req_i.addr - CtrlBase;
  assign req_ready_o = !rsp_valid_o || rsp_ready_i;
  assign accept      = req_valid_i && req_ready_o;

  ////////////////////////////////////////////////////////////////////////////
  // Register decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rd_data  = '0;
    rd_error = 1'b0;
    case (offs)
      CtrlExitOffs:  rd_data = exit_o;
      CtrlCntEnOffs: rd_data = hw_cnt_en_o;
      CtrlDramBaseOffs: begin
        rd_data  = data_t'(DramBase);
        rd_error = req_i.write;
      end
      CtrlDramEndOffs: begin
        rd_data  = data_t'(DramBase) + data_t'(DramLength);
        rd_error = req_i.write;
      end
      default: rd_error = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_o      <= '0;
      hw_cnt_en_o <= '0;
    end else if (accept && req_i.write) begin
      if (offs == CtrlExitOffs) begin
        exit_o <= apply_strb(exit_o, req_i.data, req_i.strb);
      end
      if (offs == CtrlCntEnOffs) begin
        hw_cnt_en_o <= apply_strb(hw_cnt_en_o, req_i.data, req_i.strb);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response
  ////////////////////////////////////////////////////////////////////////////

  // Writes and errors answer with zero data
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_o <= '{data: (req_i.write || rd_error) ? '0 : rd_data, error: rd_error};
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_o <= 1'b0;
    end else if (accept) begin
      rsp_valid_o <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_o <= 1'b0;
    end
  end

  a_addr_in_ctrl: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    req_valid_i |-> req_i.addr >= CtrlBase && req_i.addr < CtrlBase + CtrlLength
  );

endmodule

// File: source/l2_mem.sv
/*
 * L2 memory target
 *   word array indexed by address bits 10..3, aliasing in the window
 *   byte-strobed writes, one-cycle response held until taken
 */

module l2_mem import soc_pkg::*; (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  soc_req_t req_i,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  output soc_rsp_t rsp_o,
  output logic     rsp_valid_o,
  input  logic     rsp_ready_i
);

  data_t                 mem [L2NumWords];
  logic [L2IdxWidth-1:0] idx;
  logic                  accept;

  assign idx = req_i.addr[L2IdxWidth+2:3];

  // Free again once the held response leaves
  assign req_ready_o = !rsp_valid_o || rsp_ready_i;
  assign accept      = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i) begin
    if (accept && req_i.write) begin
      mem[idx] <= apply_strb(mem[idx], req_i.data, req_i.strb);
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_o <= '{data: req_i.write ? '0 : mem[idx], error: 1'b0};
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_o <= 1'b0;
    end else if (accept) begin
      rsp_valid_o <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_o <= 1'b0;
    end
  end

  a_addr_in_dram: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    req_valid_i |-> req_i.addr >= DramBase && req_i.addr < DramBase + DramLength
  );

endmodule

// File: source/soc_pkg.sv
/*
 * Shared SoC definitions
 *   bus widths and request/response structs
 *   memory map, L2 geometry and router depth
 *   control register offsets and a byte-strobe merge helper
 */

package soc_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [63:0] data_t;
  typedef logic [7:0]  strb_t;

  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t data;
    strb_t strb;
  } soc_req_t;

  typedef struct packed {
    data_t data;
    logic  error;
  } soc_rsp_t;

  // Where an accepted request was sent
  typedef enum logic [1:0] {
    TargetL2   = 2'd0,
    TargetCtrl = 2'd1,
    TargetNone = 2'd2
  } soc_target_e;

  ////////////////////////////////////////////////////////////////////////////
  // Memory map
  ////////////////////////////////////////////////////////////////////////////

  localparam addr_t DramBase   = 32'h8000_0000;
  localparam addr_t DramLength = 32'h4000_0000;
  localparam addr_t CtrlBase   = 32'hD000_0000;
  localparam addr_t CtrlLength = 32'h0000_1000;

  // Word index taken from address bits 10..3
  localparam int L2NumWords = 256;
  localparam int L2IdxWidth = 8;

  localparam int RouteDepth    = 4;
  localparam int RouteIdxWidth = $clog2(RouteDepth);

  localparam addr_t CtrlExitOffs     = 32'h0000_0000;
  localparam addr_t CtrlCntEnOffs    = 32'h0000_0008;
  localparam addr_t CtrlDramBaseOffs = 32'h0000_0010;
  localparam addr_t CtrlDramEndOffs  = 32'h0000_0018;

  // Replace only the strobed bytes of a word
  function automatic data_t apply_strb(data_t old_data, data_t new_data, strb_t strb);
    data_t merged;
    merged = old_data;
    for (int b = 0; b < $bits(strb_t); b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = new_data[8*b +: 8];
      end
    end
    return merged;
  endfunction

endpackage

// File: source/soc_router.sv
/*
 * Request router
 *   address decode against the DRAM and control windows
 *   in-order target tracking through a route FIFO
 *   response merge with error answers for unmapped addresses
 */

module soc_router import soc_pkg::*; (
  input  logic     clk_i,
  input  logic     arst_n_i,
  // Host side
  input  soc_req_t req_i,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  output soc_rsp_t rsp_o,
  output logic     rsp_valid_o,
  input  logic     rsp_ready_i,
  // L2 memory side
  output soc_req_t l2_req_o,
  output logic     l2_req_valid_o,
  input  logic     l2_req_ready_i,
  input  soc_rsp_t l2_rsp_i,
  input  logic     l2_rsp_valid_i,
  output logic     l2_rsp_ready_o,
  // Control register side
  output soc_req_t ctrl_req_o,
  output logic     ctrl_req_valid_o,
  input  logic     ctrl_req_ready_i,
  input  soc_rsp_t ctrl_rsp_i,
  input  logic     ctrl_rsp_valid_i,
  output logic     ctrl_rsp_ready_o
);

  soc_target_e req_tgt;
  soc_target_e head_tgt;
  logic        tgt_ready;
  logic        route_ready;
  logic        head_valid;

  ////////////////////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (req_i.addr >= DramBase && req_i.addr < DramBase + DramLength) begin
      req_tgt = TargetL2;
    end else if (req_i.addr >= CtrlBase && req_i.addr < CtrlBase + CtrlLength) begin
      req_tgt = TargetCtrl;
    end else begin
      req_tgt = TargetNone;
    end
  end

  // Unmapped requests are answered here and need no target
  always_comb begin
    case (req_tgt)
      TargetL2:   tgt_ready = l2_req_ready_i;
      TargetCtrl: tgt_ready = ctrl_req_ready_i;
      default:    tgt_ready = 1'b1;
    endcase
  end

  assign req_ready_o = route_ready && tgt_ready;

  assign l2_req_o         = req_i;
  assign ctrl_req_o       = req_i;
  assign l2_req_valid_o   = req_valid_i && route_ready && (req_tgt == TargetL2);
  assign ctrl_req_valid_o = req_valid_i && route_ready && (req_tgt == TargetCtrl);

  stream_fifo #(
    .payload_t(soc_target_e)
  ) i_route_fifo (
    .clk_i      (clk_i                                  ),
    .arst_n_i   (arst_n_i                               ),
    .in_i       (req_tgt                                ),
    .in_valid_i (req_valid_i && tgt_ready               ),
    .in_ready_o (route_ready                            ),
    .out_o      (head_tgt                               ),
    .out_valid_o(head_valid                             ),
    .out_ready_i(rsp_valid_o && rsp_ready_i             )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Response side
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rsp_o            = '0;
    rsp_valid_o      = 1'b0;
    l2_rsp_ready_o   = 1'b0;
    ctrl_rsp_ready_o = 1'b0;
    if (head_valid) begin
      case (head_tgt)
        TargetL2: begin
          rsp_o          = l2_rsp_i;
          rsp_valid_o    = l2_rsp_valid_i;
          l2_rsp_ready_o = rsp_ready_i;
        end
        TargetCtrl: begin
          rsp_o            = ctrl_rsp_i;
          rsp_valid_o      = ctrl_rsp_valid_i;
          ctrl_rsp_ready_o = rsp_ready_i;
        end
        default: begin
          rsp_o       = '{data: '0, error: 1'b1};
          rsp_valid_o = 1'b1;
        end
      endcase
    end
  end

  // Host must hold a stalled request
  a_req_stable: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    req_valid_i && !req_ready_o |=> req_valid_i && $stable(req_i)
  );

endmodule

// File: source/soc_top.sv
/*
 * SoC back end top level
 *   router with L2 memory and control register targets
 */

module soc_top import soc_pkg::*; (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  soc_req_t req_i,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  output soc_rsp_t rsp_o,
  output logic     rsp_valid_o,
  input  logic     rsp_ready_i,
  output data_t    exit_o,
  output data_t    hw_cnt_en_o
);

  soc_req_t l2_req;
  logic     l2_req_valid;
  logic     l2_req_ready;
  soc_rsp_t l2_rsp;
  logic     l2_rsp_valid;
  logic     l2_rsp_ready;

  soc_req_t ctrl_req;
  logic     ctrl_req_valid;
  logic     ctrl_req_ready;
  soc_rsp_t ctrl_rsp;
  logic     ctrl_rsp_valid;
  logic     ctrl_rsp_ready;

  soc_router i_router (
    .clk_i           (clk_i         ),
    .arst_n_i        (arst_n_i      ),
    .req_i           (req_i         ),
    .req_valid_i     (req_valid_i   ),
    .req_ready_o     (req_ready_o   ),
    .rsp_o           (rsp_o         ),
    .rsp_valid_o     (rsp_valid_o   ),
    .rsp_ready_i     (rsp_ready_i   ),
    .l2_req_o        (l2_req        ),
    .l2_req_valid_o  (l2_req_valid  ),
    .l2_req_ready_i  (l2_req_ready  ),
    .l2_rsp_i        (l2_rsp        ),
    .l2_rsp_valid_i  (l2_rsp_valid  ),
    .l2_rsp_ready_o  (l2_rsp_ready  ),
    .ctrl_req_o      (ctrl_req      ),
    .ctrl_req_valid_o(ctrl_req_valid),
    .ctrl_req_ready_i(ctrl_req_ready),
    .ctrl_rsp_i      (ctrl_rsp      ),
    .ctrl_rsp_valid_i(ctrl_rsp_valid),
    .ctrl_rsp_ready_o(ctrl_rsp_ready)
  );

  l2_mem i_l2_mem (
    .clk_i      (clk_i       ),
    .arst_n_i   (arst_n_i    ),
    .req_i      (l2_req      ),
    .req_valid_i(l2_req_valid),
    .req_ready_o(l2_req_ready),
    .rsp_o      (l2_rsp      ),
    .rsp_valid_o(l2_rsp_valid),
    .rsp_ready_i(l2_rsp_ready)
  );

  ctrl_regs i_ctrl_regs (
    .clk_i      (clk_i         ),
    .arst_n_i   (arst_n_i      ),
    .req_i      (ctrl_req      ),
    .req_valid_i(ctrl_req_valid),
    .req_ready_o(ctrl_req_ready),
    .rsp_o      (ctrl_rsp      ),
    .rsp_valid_o(ctrl_rsp_valid),
    .rsp_ready_i(ctrl_rsp_ready),
    .exit_o     (exit_o        ),
    .hw_cnt_en_o(hw_cnt_en_o   )
  );

endmodule

// File: source/stream_fifo.sv
/*
 * Valid/ready FIFO of RouteDepth entries
 *   circular buffer with read/write pointers and a fill count
 *   payload type given by parameter
 */

module stream_fifo import soc_pkg::*; #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  payload_t in_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  output payload_t out_o,
  output logic     out_valid_o,
  input  logic     out_ready_i
);

  payload_t                 mem [RouteDepth];
  logic [RouteIdxWidth-1:0] wr_ptr;
  logic [RouteIdxWidth-1:0] rd_ptr;
  logic [RouteIdxWidth:0]   count;
  logic                     push;
  logic                     pop;

  assign in_ready_o  = (count != (RouteIdxWidth+1)'(RouteDepth));
  assign out_valid_o = (count != '0);
  assign out_o       = mem[rd_ptr];

  assign push = in_valid_i && in_ready_o;
  assign pop  = out_valid_o && out_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr] <= in_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == RouteIdxWidth'(RouteDepth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == RouteIdxWidth'(RouteDepth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_count_in_range: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    count <= (RouteIdxWidth+1)'(RouteDepth)
  );

endmodule

// File: sources.f
+incdir+test
source/soc_pkg.sv
source/stream_fifo.sv
source/soc_router.sv
source/l2_mem.sv
source/ctrl_regs.sv
source/soc_top.sv
test/tb_soc_top.sv

// File: test/soc_model.svh
/*
 * Reference model of the SoC back end
 *   L2 contents, exit and counter-enable registers
 *   address decode and expected response of one access
 */

`ifndef SOC_MODEL_SVH
`define SOC_MODEL_SVH

data_t                 model_mem [L2NumWords];
bit                    model_written [L2NumWords];
logic [L2IdxWidth-1:0] written_idx [$];
data_t                 model_exit   = '0;
data_t                 model_cnt_en = '0;

function automatic data_t merge_bytes(data_t old_word, data_t new_word, strb_t strb);
  data_t word;
  word = old_word;
  for (int i = 0; i < 8; i++) begin
    if (strb[i]) begin
      word[8*i +: 8] = new_word[8*i +: 8];
    end
  end
  return word;
endfunction

function automatic soc_target_e decode_addr(addr_t addr);
  if (addr >= DramBase && addr < DramBase + DramLength) begin
    return TargetL2;
  end
  if (addr >= CtrlBase && addr < CtrlBase + CtrlLength) begin
    return TargetCtrl;
  end
  return TargetNone;
endfunction

// Updates the model state as the access is accepted
function automatic soc_rsp_t predict_access(soc_req_t req);
  soc_rsp_t              rsp;
  logic [L2IdxWidth-1:0] idx;
  addr_t                 offs;
  rsp  = '{data: '0, error: 1'b0};
  idx  = req.addr[10:3];
  offs = req.addr - CtrlBase;
  case (decode_addr(req.addr))
    TargetL2: begin
      if (req.write) begin
        model_mem[idx] = merge_bytes(model_mem[idx], req.data, req.strb);
        if (!model_written[idx]) begin
          written_idx.push_back(idx);
        end
        model_written[idx] = 1'b1;
      end else begin
        rsp.data = model_mem[idx];
      end
    end
    TargetCtrl: begin
      if (offs == CtrlExitOffs) begin
        if (req.write) model_exit = merge_bytes(model_exit, req.data, req.strb);
        else rsp.data = model_exit;
      end else if (offs == CtrlCntEnOffs) begin
        if (req.write) model_cnt_en = merge_bytes(model_cnt_en, req.data, req.strb);
        else rsp.data = model_cnt_en;
      end else if (offs == CtrlDramBaseOffs && !req.write) begin
        rsp.data = 64'(DramBase);
      end else if (offs == CtrlDramEndOffs && !req.write) begin
        rsp.data = 64'(DramBase) + 64'(DramLength);
      end else begin
        rsp.error = 1'b1;
      end
    end
    default: rsp.error = 1'b1;
  endcase
  return rsp;
endfunction

`endif

// File: test/tb_soc_top.sv
/*
 * Testbench for the SoC back end
 *   random traffic over L2, control and unmapped space
 *   in-order response checking against the included model
 */

module tb_soc_top import soc_pkg::*; ();

  localparam int    NumReqs       = 400;
  localparam int    TimeoutCycles = 4 * NumReqs + 100;
  localparam addr_t UartBase      = 32'h1000_0000;

  logic     clk_i = 1'b0;
  logic     arst_n_i;
  soc_req_t req_i;
  logic     req_valid_i;
  logic     req_ready_o;
  soc_rsp_t rsp_o;
  logic     rsp_valid_o;
  logic     rsp_ready_i;
  data_t    exit_o;
  data_t    hw_cnt_en_o;

  logic [31:0] rng_state = 32'd5;
  soc_rsp_t    expected [$];
  int          accepted  = 0;
  int          chosen    = 0;
  int          cycles    = 0;
  logic        req_taken = 1'b0;

  `include "soc_model.svh"

  soc_top i_soc_top (
    .clk_i      (clk_i      ),
    .arst_n_i   (arst_n_i   ),
    .req_i      (req_i      ),
    .req_valid_i(req_valid_i),
    .req_ready_o(req_ready_o),
    .rsp_o      (rsp_o      ),
    .rsp_valid_o(rsp_valid_o),
    .rsp_ready_i(rsp_ready_i),
    .exit_o     (exit_o     ),
    .hw_cnt_en_o(hw_cnt_en_o)
  );

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic fail_run(input string line);
    $display("%s", line);
    $display("Result: FAILED");
    $fatal(1, "run stopped");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  function automatic soc_req_t random_request();
    soc_req_t              req;
    logic [31:0]           r;
    logic [31:0]           r2;
    logic [2:0]            kind;
    logic [L2IdxWidth-1:0] idx;
    addr_t                 offs;
    r        = xorshift32();
    r2       = xorshift32();
    kind     = r[2:0];
    req      = '0;
    req.data = {xorshift32(), xorshift32()};
    req.strb = r[15:8];
    if ((kind == 3'd3 || kind == 3'd4) && written_idx.size() == 0) begin
      kind = 3'd0;
    end
    case (kind)
      3'd0, 3'd1, 3'd2: begin
        req.write = 1'b1;
        req.addr  = DramBase | (r2 & 32'h3FFF_FFF8);
        idx       = req.addr[10:3];
        // First write to a word fills it completely
        if (!model_written[idx]) req.strb = 8'hFF;
      end
      3'd3, 3'd4: begin
        idx      = written_idx[r2 % written_idx.size()];
        // Random upper bits alias onto the same word
        req.addr = DramBase | (xorshift32() & 32'h3FFF_F800) | {21'd0, idx, 3'd0};
      end
      3'd5: begin
        req.write = r2[2];
        req.addr  = CtrlBase + {27'd0, r2[1:0], 3'd0};
      end
      3'd6: begin
        offs = r2 & 32'h0000_0FFF;
        if (offs < 32'h20 && offs[2:0] == 3'd0) offs = offs + 32'h20;
        req.write = r2[16];
        req.addr  = CtrlBase + offs;
      end
      default: begin
        req.write = r[3];
        req.addr  = r2[31] ? UartBase + (r2 & 32'h0000_FFFF) : r2 & 32'h7FFF_FFFF;
      end
    endcase
    return req;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic take_response();
    soc_rsp_t exp;
    assert (expected.size() != 0) else begin
      fail_run("A response arrived while no request was outstanding");
    end
    exp = expected.pop_front();
    assert (rsp_o === exp) else begin
      fail_run($sformatf("** Error at %0t: response data %h error %b, expected data %h error %b",
                         $time, rsp_o.data, rsp_o.error, exp.data, exp.error));
    end
  endtask

  task automatic check_outputs();
    assert (exit_o === model_exit && hw_cnt_en_o === model_cnt_en) else begin
      fail_run($sformatf("** Error at %0t: exit %h cnt_en %h, expected exit %h cnt_en %h",
                         $time, exit_o, hw_cnt_en_o, model_exit, model_cnt_en));
    end
  endtask

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TimeoutCycles) begin
      fail_run($sformatf("Timeout: the run did not finish within %0d cycles", TimeoutCycles));
    end
  end

  initial begin
    arst_n_i    = 1'b0;
    req_i       = '0;
    req_valid_i = 1'b0;
    rsp_ready_i = 1'b0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    assert (rsp_valid_o === 1'b0 && req_ready_o === 1'b1) else begin
      fail_run($sformatf("** Error at %0t: handshake outputs wrong after reset", $time));
    end
    check_outputs();

    while (accepted < NumReqs || expected.size() != 0) begin
      @(posedge clk_i);
      // Take the response first as it belongs to an earlier request
      if (rsp_valid_o && rsp_ready_i) take_response();
      req_taken = req_valid_i && req_ready_o;
      if (req_taken) begin
        expected.push_back(predict_access(req_i));
        accepted++;
      end
      @(negedge clk_i);
      check_outputs();
      if (!req_valid_i || req_taken) begin
        req_valid_i = 1'b0;
        if (chosen < NumReqs && xorshift32() % 4 != 0) begin
          req_i       = random_request();
          req_valid_i = 1'b1;
          chosen++;
        end
      end
      rsp_ready_i = (xorshift32() % 4 != 0);
    end

    // Nothing may remain once every expected response is in
    assert (rsp_valid_o === 1'b0) else begin
      fail_run("A response arrived after the last expected one");
    end

    $display("Result: PASSED");
    $finish;
  end

endmodule
